// File: design/clk_sync_pkg.sv
package clk_sync_pkg;

	localparam int default_nodes = 4;
	localparam int default_mbox_base = 64; // First high-priority mailbox.
	localparam int msg_len = 16; // Bytes per mailbox message.
	localparam int ptr_w = 10;
	localparam int ts_w = 16;

	// Byte offsets inside one message.
	localparam int flags_off = 2;
	localparam int ts_off = 4;
	localparam int ts_slots = 4;

	function automatic logic [ptr_w-1:0] mbox_addr(input int base, input int node,
			input int off);
		return ptr_w'(base + node * msg_len + off);
	endfunction

	// Slot k sits at 4+2k (low) and 5+2k (high).
	function automatic logic [ptr_w-1:0] ts_addr(input int base, input int node,
			input int slot, input bit hi);
		return mbox_addr(base, node, ts_off + 2 * slot + int'(hi));
	endfunction

	typedef union packed {
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} bytes;
		struct packed {
			logic [12:0] reserved;
			logic        scope_req;
			logic        slave_ready;
			logic        sync_req;
		} fields;
	} flags_word_u;

endpackage

// File: design/local_period_counter.sv
`timescale 1ns/100ps

module local_period_counter #(
	parameter int CYCLE_PERIOD = 1000
) (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic [1:0]                    snap_i,
	output logic [clk_sync_pkg::ts_w-1:0] cycle_count_o,
	output logic [clk_sync_pkg::ts_w-1:0] snap_tx_o,
	output logic [clk_sync_pkg::ts_w-1:0] snap_rx_o
);
	import clk_sync_pkg::*;

	localparam logic [ts_w-1:0] last_count = ts_w'(CYCLE_PERIOD - 1);

	// Free-running period count.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cycle_count_o <= '0;
		end else if (cycle_count_o == last_count) begin
			cycle_count_o <= '0; // Wrap at end of period.
		end else begin
			cycle_count_o <= cycle_count_o + 1'b1;
		end
	end

	// Snapshot registers hold the count seen while the strobe was high.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			snap_tx_o <= '0;
			snap_rx_o <= '0;
		end else begin
			if (snap_i[0]) begin
				snap_tx_o <= cycle_count_o; // Tx.
			end
			if (snap_i[1]) begin
				snap_rx_o <= cycle_count_o; // Rx.
			end
		end
	end

endmodule

// File: design/mailbox_capture.sv
`timescale 1ns/100ps

module mailbox_capture #(
	parameter int NODES = clk_sync_pkg::default_nodes,
	parameter int MBOX_BASE = clk_sync_pkg::default_mbox_base
) (
	input  logic                                       clk_i,
	input  logic                                       rst_i,
	input  logic                                       rx_we_i,
	input  logic [clk_sync_pkg::ptr_w-1:0]             rx_addr_i,
	input  logic [7:0]                                 rx_data_i,
	input  logic                                       pulse_i,
	input  logic [$clog2(NODES*clk_sync_pkg::ts_slots)-1:0] rd_addr_i,
	output logic [clk_sync_pkg::ts_w-1:0]              rd_data_o,
	output logic [NODES-1:0]                           rdy_lo_o,
	output logic [NODES-1:0]                           rdy_hi_o,
	output clk_sync_pkg::flags_word_u [NODES-1:0]      flags_o
);
	import clk_sync_pkg::*;

	localparam int n_slots = NODES * ts_slots;

	logic [7:0] ts_lo_mem [n_slots];
	logic [7:0] ts_hi_mem [n_slots];

	logic [n_slots-1:0] lo_hit;
	logic [n_slots-1:0] hi_hit;
	logic [NODES-1:0] node_lo_wr;
	logic [NODES-1:0] node_hi_wr;
	logic [NODES-1:0] flag_lo_hit;
	logic [NODES-1:0] flag_hi_hit;
	logic [NODES-1:0] chain_ok;
	logic wr_en;

	assign wr_en = rx_we_i && !pulse_i; // Write is lost under the pulse.

	// Address decode against the mailbox layout.
	always_comb begin
		for (int n = 0; n < NODES; n++) begin
			flag_lo_hit[n] = wr_en && rx_addr_i == mbox_addr(MBOX_BASE, n, flags_off);
			flag_hi_hit[n] = wr_en && rx_addr_i == mbox_addr(MBOX_BASE, n, flags_off + 1);
			for (int k = 0; k < ts_slots; k++) begin
				lo_hit[n*ts_slots+k] = wr_en && rx_addr_i == ts_addr(MBOX_BASE, n, k, 1'b0);
				hi_hit[n*ts_slots+k] = wr_en && rx_addr_i == ts_addr(MBOX_BASE, n, k, 1'b1);
			end
			node_lo_wr[n] = |lo_hit[n*ts_slots +: ts_slots];
			node_hi_wr[n] = |hi_hit[n*ts_slots +: ts_slots];
		end
	end

	// A node may only become ready once the node before it is complete.
	always_comb begin
		chain_ok[0] = 1'b1;
		for (int n = 1; n < NODES; n++) begin
			chain_ok[n] = rdy_lo_o[n-1] && rdy_hi_o[n-1];
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rdy_lo_o <= '0;
			rdy_hi_o <= '0;
			flags_o <= '0;
		end else if (pulse_i) begin
			rdy_lo_o <= '0; // New sync period.
			rdy_hi_o <= '0;
			flags_o <= '0;
		end else begin
			for (int n = 0; n < NODES; n++) begin
				if (node_lo_wr[n] && chain_ok[n]) begin
					rdy_lo_o[n] <= 1'b1;
				end
				if (node_hi_wr[n] && chain_ok[n] && rdy_lo_o[n]) begin
					rdy_hi_o[n] <= 1'b1;
				end
				if (flag_lo_hit[n]) begin
					flags_o[n].bytes.lo <= rx_data_i;
				end
				if (flag_hi_hit[n]) begin
					flags_o[n].bytes.hi <= rx_data_i;
				end
			end
		end
	end

	// Two byte banks, one per timestamp half.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < n_slots; i++) begin
				ts_lo_mem[i] <= '0;
				ts_hi_mem[i] <= '0;
			end
		end else begin
			for (int i = 0; i < n_slots; i++) begin
				if (lo_hit[i]) begin
					ts_lo_mem[i] <= rx_data_i;
				end
				if (hi_hit[i]) begin
					ts_hi_mem[i] <= rx_data_i;
				end
			end
		end
	end

	assign rd_data_o = {ts_hi_mem[rd_addr_i], ts_lo_mem[rd_addr_i]};

endmodule

// File: design/link_calc.sv
`timescale 1ns/100ps

module link_calc #(
	parameter int NODES = clk_sync_pkg::default_nodes
) (
	input  logic                                            clk_i,
	input  logic                                            rst_i,
	input  logic                                            pulse_i,
	input  logic [clk_sync_pkg::ts_w-1:0]                   snap_tx_i,
	input  logic [clk_sync_pkg::ts_w-1:0]                   snap_rx_i,
	output logic [$clog2(NODES*clk_sync_pkg::ts_slots)-1:0] rd_addr_o,
	input  logic [clk_sync_pkg::ts_w-1:0]                   rd_data_i,
	output logic                                            res_we_o,
	output logic [$clog2(NODES)-1:0]                        res_idx_o,
	output logic [clk_sync_pkg::ts_w-1:0]                   res_delay_o,
	output logic [clk_sync_pkg::ts_w-1:0]                   res_offset_o,
	output logic                                            calc_busy_o
);
	import clk_sync_pkg::*;

	localparam int idx_w = $clog2(NODES);
	localparam int addr_w = $clog2(NODES * ts_slots);

	typedef enum logic [2:0] {
		st_idle,
		st_slot0,
		st_slot1,
		st_prev2,
		st_prev3,
		st_write
	} state_t;

	state_t state_q;
	logic [idx_w-1:0] node_q;
	logic [ts_w-1:0] snap_tx_q;
	logic [ts_w-1:0] snap_rx_q;
	logic [ts_w-1:0] acc_delay_q;
	logic [ts_w-1:0] acc_offset_q;
	logic [ts_w-1:0] operand;
	logic [addr_w-1:0] base_addr;
	logic first_node;

	assign first_node = node_q == '0;
	assign base_addr = addr_w'(node_q * ts_slots);

	// Previous node's slots 2 and 3 lie just below this node's slot 0.
	always_comb begin
		case (state_q)
			st_slot1: rd_addr_o = base_addr + addr_w'(1);
			st_prev2: rd_addr_o = base_addr - addr_w'(2);
			st_prev3: rd_addr_o = base_addr - addr_w'(1);
			default:  rd_addr_o = base_addr;
		endcase
	end

	// Node 0 has no upstream slave, so the master's own snapshots stand in.
	always_comb begin
		operand = rd_data_i;
		if (first_node && state_q == st_prev2) begin
			operand = snap_tx_q;
		end else if (first_node && state_q == st_prev3) begin
			operand = snap_rx_q;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= st_idle;
			node_q <= '0;
			snap_tx_q <= '0;
			snap_rx_q <= '0;
			acc_delay_q <= '0;
			acc_offset_q <= '0;
		end else begin
			case (state_q)
				st_idle: begin
					if (pulse_i) begin
						snap_tx_q <= snap_tx_i;
						snap_rx_q <= snap_rx_i;
						node_q <= '0;
						acc_delay_q <= '0;
						acc_offset_q <= '0;
						state_q <= st_slot0;
					end
				end
				st_slot0: begin
					acc_delay_q <= acc_delay_q + operand;
					acc_offset_q <= acc_offset_q + operand;
					state_q <= st_slot1;
				end
				st_slot1: begin
					acc_delay_q <= acc_delay_q - operand;
					acc_offset_q <= acc_offset_q + operand;
					state_q <= st_prev2;
				end
				st_prev2: begin
					acc_delay_q <= acc_delay_q - operand;
					acc_offset_q <= acc_offset_q - operand;
					state_q <= st_prev3;
				end
				st_prev3: begin
					acc_delay_q <= acc_delay_q + operand; // Delay adds P3, offset drops it.
					acc_offset_q <= acc_offset_q - operand;
					state_q <= st_write;
				end
				st_write: begin
					acc_delay_q <= '0;
					acc_offset_q <= '0;
					if (node_q == idx_w'(NODES - 1)) begin
						node_q <= '0;
						state_q <= st_idle;
					end else begin
						node_q <= node_q + 1'b1;
						state_q <= st_slot0;
					end
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	assign res_we_o = state_q == st_write;
	assign res_idx_o = node_q;
	assign res_delay_o = acc_delay_q;
	assign res_offset_o = acc_offset_q;
	assign calc_busy_o = state_q != st_idle;

endmodule

// File: design/sync_report.sv
`timescale 1ns/100ps

module sync_report #(
	parameter int NODES = clk_sync_pkg::default_nodes
) (
	input  logic                                    clk_i,
	input  logic                                    rst_i,
	input  logic                                    pulse_i,
	input  logic [NODES-1:0]                        rdy_lo_i,
	input  logic [NODES-1:0]                        rdy_hi_i,
	input  clk_sync_pkg::flags_word_u [NODES-1:0]   flags_i,
	input  logic                                    res_we_i,
	input  logic [$clog2(NODES)-1:0]                res_idx_i,
	input  logic [clk_sync_pkg::ts_w-1:0]           res_delay_i,
	input  logic [clk_sync_pkg::ts_w-1:0]           res_offset_i,
	output logic [NODES-1:0]                        rx_ok_o,
	output logic [NODES-1:0]                        sync_ok_o,
	output logic [NODES-1:0]                        slave_rdy_o,
	output logic [NODES-1:0]                        scope_trig_o,
	output logic [NODES*clk_sync_pkg::ts_w-1:0]     comm_delays_o,
	output logic [NODES*clk_sync_pkg::ts_w-1:0]     clock_offsets_o
);
	import clk_sync_pkg::*;

	logic [NODES-1:0] rx_ok_d;
	logic [NODES-1:0] sync_ok_d;
	logic [NODES-1:0] slave_rdy_d;
	logic [NODES-1:0] scope_trig_d;

	always_comb begin
		rx_ok_d = rdy_lo_i & rdy_hi_i; // Both halves of the chain arrived.
		for (int n = 0; n < NODES; n++) begin
			sync_ok_d[n] = rx_ok_d[n] && flags_i[n].fields.sync_req;
			slave_rdy_d[n] = sync_ok_d[n] && flags_i[n].fields.slave_ready;
			scope_trig_d[n] = rx_ok_d[n] && flags_i[n].fields.scope_req;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rx_ok_o <= '0;
			sync_ok_o <= '0;
			slave_rdy_o <= '0;
			scope_trig_o <= '0;
			comm_delays_o <= '0;
			clock_offsets_o <= '0;
		end else begin
			if (pulse_i) begin
				rx_ok_o <= rx_ok_d;
				sync_ok_o <= sync_ok_d;
				slave_rdy_o <= slave_rdy_d;
				scope_trig_o <= scope_trig_d;
			end
			if (res_we_i) begin
				comm_delays_o[res_idx_i*ts_w +: ts_w] <= res_delay_i;
				clock_offsets_o[res_idx_i*ts_w +: ts_w] <= res_offset_i;
			end
		end
	end

endmodule

// File: design/master_sync_top.sv
`timescale 1ns/100ps

module master_sync_top #(
	parameter int NODES = clk_sync_pkg::default_nodes,
	parameter int MBOX_BASE = clk_sync_pkg::default_mbox_base,
	parameter int CYCLE_PERIOD = 1000
) (
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  logic                                rx_we_i,
	input  logic [clk_sync_pkg::ptr_w-1:0]      rx_addr_i,
	input  logic [7:0]                          rx_data_i,
	input  logic                                pulse_i,
	input  logic [1:0]                          snap_i,
	output logic [clk_sync_pkg::ts_w-1:0]       cycle_count_o,
	output logic                                calc_busy_o,
	output logic [NODES-1:0]                    rx_ok_o,
	output logic [NODES-1:0]                    sync_ok_o,
	output logic [NODES-1:0]                    slave_rdy_o,
	output logic [NODES-1:0]                    scope_trig_o,
	output logic [NODES*clk_sync_pkg::ts_w-1:0] comm_delays_o,
	output logic [NODES*clk_sync_pkg::ts_w-1:0] clock_offsets_o
);
	import clk_sync_pkg::*;

	logic [ts_w-1:0] snap_tx;
	logic [ts_w-1:0] snap_rx;
	logic [$clog2(NODES*ts_slots)-1:0] rd_addr;
	logic [ts_w-1:0] rd_data;
	logic [NODES-1:0] rdy_lo;
	logic [NODES-1:0] rdy_hi;
	flags_word_u [NODES-1:0] flags;
	logic res_we;
	logic [$clog2(NODES)-1:0] res_idx;
	logic [ts_w-1:0] res_delay;
	logic [ts_w-1:0] res_offset;

	local_period_counter #(.CYCLE_PERIOD(CYCLE_PERIOD)) u_local_period_counter (
		.clk_i(clk_i), .rst_i(rst_i), .snap_i(snap_i),
		.cycle_count_o(cycle_count_o), .snap_tx_o(snap_tx), .snap_rx_o(snap_rx)
	);

	mailbox_capture #(.NODES(NODES), .MBOX_BASE(MBOX_BASE)) u_mailbox_capture (
		.clk_i(clk_i), .rst_i(rst_i), .rx_we_i(rx_we_i), .rx_addr_i(rx_addr_i),
		.rx_data_i(rx_data_i), .pulse_i(pulse_i), .rd_addr_i(rd_addr),
		.rd_data_o(rd_data), .rdy_lo_o(rdy_lo), .rdy_hi_o(rdy_hi), .flags_o(flags)
	);

	link_calc #(.NODES(NODES)) u_link_calc (
		.clk_i(clk_i), .rst_i(rst_i), .pulse_i(pulse_i),
		.snap_tx_i(snap_tx), .snap_rx_i(snap_rx),
		.rd_addr_o(rd_addr), .rd_data_i(rd_data),
		.res_we_o(res_we), .res_idx_o(res_idx),
		.res_delay_o(res_delay), .res_offset_o(res_offset),
		.calc_busy_o(calc_busy_o)
	);

	sync_report #(.NODES(NODES)) u_sync_report (
		.clk_i(clk_i), .rst_i(rst_i), .pulse_i(pulse_i),
		.rdy_lo_i(rdy_lo), .rdy_hi_i(rdy_hi), .flags_i(flags),
		.res_we_i(res_we), .res_idx_i(res_idx),
		.res_delay_i(res_delay), .res_offset_i(res_offset),
		.rx_ok_o(rx_ok_o), .sync_ok_o(sync_ok_o),
		.slave_rdy_o(slave_rdy_o), .scope_trig_o(scope_trig_o),
		.comm_delays_o(comm_delays_o), .clock_offsets_o(clock_offsets_o)
	);

endmodule

// File: verification/master_sync_props.sv
`timescale 1ns/100ps

module master_sync_props #(
	parameter int NODES = 4
) (
	input logic             clk_i,
	input logic             rst_i,
	input logic             calc_busy_i,
	input logic             res_we_i,
	input logic [NODES-1:0] rx_ok_i
);
	localparam int busy_cycles = 5 * NODES; // Five sequencer states per node.

	busy_length: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(calc_busy_i) |-> calc_busy_i [*busy_cycles] ##1 !calc_busy_i)
		else $error("calc_busy_o held for the wrong number of cycles");

	// Each node's result lands on the fifth cycle of its own step.
	write_spacing: assert property (@(posedge clk_i) disable iff (rst_i)
		res_we_i |-> $past(calc_busy_i, 4) ##1 !res_we_i [*4])
		else $error("result write too early or too soon after the previous one");

	// Readiness grows from node 0 upward, so rx_ok_o holds only low ones.
	rx_chain: assert property (@(posedge clk_i) disable iff (rst_i)
		((rx_ok_i + 1'b1) & rx_ok_i) == '0)
		else $error("rx_ok_o set for a node whose predecessor was not ready");

endmodule

bind master_sync_top master_sync_props #(.NODES(NODES)) u_master_sync_props (
	.clk_i(clk_i), .rst_i(rst_i), .calc_busy_i(calc_busy_o), .res_we_i(res_we),
	.rx_ok_i(rx_ok_o)
);

// File: verification/master_sync_tb.sv
`timescale 1ns/100ps

module master_sync_tb;
	localparam int nodes = 4;
	localparam int period = 1000;
	localparam int mbox_base = 64;
	localparam int msg_bytes = 16;
	localparam int n_tests = 4;

	logic clk;
	logic rst;
	logic rx_we;
	logic [9:0] rx_addr;
	logic [7:0] rx_data;
	logic pulse;
	logic [1:0] snap;
	logic [15:0] cycle_count;
	logic calc_busy;
	logic [nodes-1:0] rx_ok;
	logic [nodes-1:0] sync_ok;
	logic [nodes-1:0] slave_rdy;
	logic [nodes-1:0] scope_trig;
	logic [nodes*16-1:0] comm_delays;
	logic [nodes*16-1:0] clock_offsets;

	// Flag low byte, nodes written and expected status vectors for each test.
	string tab_name [n_tests] = '{"all nodes sync_req", "mixed flag fields",
		"node 1 skipped", "pulse without writes"};
	logic [7:0] tab_flags [n_tests][nodes] = '{'{8'h01, 8'h01, 8'h01, 8'h01},
		'{8'h01, 8'h03, 8'h04, 8'h07}, '{8'h03, 8'h03, 8'h03, 8'h03},
		'{8'h07, 8'h07, 8'h07, 8'h07}};
	logic [nodes-1:0] tab_mask [n_tests] = '{4'b1111, 4'b1111, 4'b1101, 4'b0000};
	logic [nodes-1:0] tab_rx_ok [n_tests] = '{4'b1111, 4'b1111, 4'b0001, 4'b0000};
	logic [nodes-1:0] tab_sync_ok [n_tests] = '{4'b1111, 4'b1011, 4'b0001, 4'b0000};
	logic [nodes-1:0] tab_slave_rdy [n_tests] = '{4'b0000, 4'b1010, 4'b0001, 4'b0000};
	logic [nodes-1:0] tab_scope [n_tests] = '{4'b0000, 4'b1100, 4'b0000, 4'b0000};
	logic [15:0] tab_ts [n_tests][nodes][4];
	logic [15:0] model_ts [nodes][4]; // What the mailbox memory should hold.

	int seed = 32'ha0be;
	int test_errs;
	int total_errs = 0;
	int passed = 0;
	int failed = 0;

	master_sync_top #(.NODES(nodes), .MBOX_BASE(mbox_base), .CYCLE_PERIOD(period))
	u_master_sync_top (
		.clk_i(clk), .rst_i(rst), .rx_we_i(rx_we), .rx_addr_i(rx_addr),
		.rx_data_i(rx_data), .pulse_i(pulse), .snap_i(snap),
		.cycle_count_o(cycle_count), .calc_busy_o(calc_busy),
		.rx_ok_o(rx_ok), .sync_ok_o(sync_ok), .slave_rdy_o(slave_rdy),
		.scope_trig_o(scope_trig), .comm_delays_o(comm_delays),
		.clock_offsets_o(clock_offsets)
	);

	always #10 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		assert (got === exp) else begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		$display("test %s: %s, %0d errors", name, (test_errs == 0) ? "ok" : "bad", test_errs);
		total_errs += test_errs;
		if (test_errs == 0) passed++;
		else failed++;
	endtask

	task automatic write_byte(input int addr, input logic [7:0] data);
		@(negedge clk);
		rx_we = 1'b1;
		rx_addr = 10'(addr);
		rx_data = data;
	endtask

	// Flag bytes go first and each slot sends its low byte before its high byte.
	task automatic write_node(input int t, input int n);
		int base;
		base = mbox_base + n * msg_bytes;
		write_byte(base + 2, tab_flags[t][n]);
		write_byte(base + 3, 8'h00);
		for (int k = 0; k < 4; k++) begin
			write_byte(base + 4 + 2 * k, tab_ts[t][n][k][7:0]);
			write_byte(base + 5 + 2 * k, tab_ts[t][n][k][15:8]);
			model_ts[n][k] = tab_ts[t][n][k];
		end
	endtask

	task automatic wait_busy(input logic level);
		int cycles;
		cycles = 0;
		while (calc_busy !== level) begin
			@(negedge clk);
			cycles++;
			if (cycles > 200) abort_run($sformatf("timeout waiting for calc_busy_o = %b", level));
		end
	endtask

	task automatic run_entry(input int t);
		logic [15:0] tx_cnt;
		logic [15:0] rx_cnt;
		logic [15:0] p2;
		logic [15:0] p3;
		logic [15:0] t0;
		logic [15:0] t1;
		test_errs = 0;
		for (int n = 0; n < nodes; n++) begin
			if (tab_mask[t][n]) write_node(t, n);
		end
		@(negedge clk);
		rx_we = 1'b0;
		snap = 2'b01;
		tx_cnt = cycle_count; // Count the tx snapshot will capture.
		@(negedge clk);
		snap = 2'b10;
		rx_cnt = cycle_count;
		@(negedge clk);
		snap = 2'b00;
		pulse = 1'b1;
		@(negedge clk);
		pulse = 1'b0;
		wait_busy(1'b1);
		wait_busy(1'b0);
		for (int n = 0; n < nodes; n++) begin
			t0 = model_ts[n][0];
			t1 = model_ts[n][1];
			p2 = (n == 0) ? tx_cnt : model_ts[n-1][2];
			p3 = (n == 0) ? rx_cnt : model_ts[n-1][3];
			check_value($sformatf("comm_delays_o[%0d]", n), comm_delays[n*16 +: 16],
				t0 - t1 - p2 + p3);
			check_value($sformatf("clock_offsets_o[%0d]", n), clock_offsets[n*16 +: 16],
				t0 + t1 - p2 - p3);
		end
		check_value("rx_ok_o", 16'(rx_ok), 16'(tab_rx_ok[t]));
		check_value("sync_ok_o", 16'(sync_ok), 16'(tab_sync_ok[t]));
		check_value("slave_rdy_o", 16'(slave_rdy), 16'(tab_slave_rdy[t]));
		check_value("scope_trig_o", 16'(scope_trig), 16'(tab_scope[t]));
		finish_test(tab_name[t]);
	endtask

	initial begin
		int cycles;
		clk = 1'b0;
		rst = 1'b1;
		rx_we = 1'b0;
		rx_addr = '0;
		rx_data = '0;
		pulse = 1'b0;
		snap = 2'b00;
		for (int t = 0; t < n_tests; t++)
			for (int n = 0; n < nodes; n++)
				for (int k = 0; k < 4; k++)
					tab_ts[t][n][k] = 16'($random(seed));
		for (int n = 0; n < nodes; n++)
			for (int k = 0; k < 4; k++)
				model_ts[n][k] = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_errs = 0;
		check_value("calc_busy_o", 16'(calc_busy), 16'h0);
		check_value("rx_ok_o", 16'(rx_ok), 16'h0);
		check_value("sync_ok_o", 16'(sync_ok), 16'h0);
		check_value("slave_rdy_o", 16'(slave_rdy), 16'h0);
		check_value("scope_trig_o", 16'(scope_trig), 16'h0);
		check_value("comm_delays_o[0]", comm_delays[15:0], 16'h0);
		cycles = 0;
		while (cycle_count !== 16'(period - 1)) begin
			@(negedge clk);
			cycles++;
			if (cycles > period + 10) abort_run("cycle_count_o never reached the period end");
		end
		@(negedge clk);
		check_value("cycle_count_o", cycle_count, 16'h0); // Wrapped.
		finish_test("reset and wrap");

		for (int t = 0; t < n_tests; t++) run_entry(t);

		$display("tests %0d, passed %0d, failed %0d, errors %0d", n_tests + 1, passed,
			failed, total_errs);
		if (total_errs == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: src.f
design/clk_sync_pkg.sv
design/local_period_counter.sv
design/mailbox_capture.sv
design/link_calc.sv
design/sync_report.sv
design/master_sync_top.sv
verification/master_sync_props.sv
verification/master_sync_tb.sv
